// ==== nnLayer_defines.svh ====
`ifndef NN_LAYER_DEFINES_SVH
`define NN_LAYER_DEFINES_SVH

// Layer geometry.
`define NN_NUM_INPUTS 15
`define NN_NUM_NEURONS 8

`define NN_WORD 32

// Output slice taken from a non-negative sum.
`define NN_OUT_MSB 28
`define NN_OUT_LSB 13

`define NN_ADDR_W 12

// Byte addresses, all registers word aligned.
`define NN_CTRL_ADDR 12'h000
`define NN_STATUS_ADDR 12'h004
`define NN_INPUT_BASE 12'h040
`define NN_BIAS_BASE 12'h100
`define NN_WEIGHT_BASE 12'h200 // Weight (n, i) at base + 4*(16*n + i).
`define NN_OUTPUT_BASE 12'h400

`endif

// ==== nnLayerPkg.sv ====
`include "nnLayer_defines.svh"

package nnLayerPkg;

	typedef logic signed [`NN_WORD-1:0] nnWord_t;
	typedef logic [3:0] inputIdx_t;
	typedef logic [2:0] neuronIdx_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`NN_ADDR_W-1:0] paddr;
		logic [`NN_WORD-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [`NN_WORD-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

	// One multiply-accumulate step of the sequencer.
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		neuronIdx_t neuron;
		inputIdx_t inputIdx;
	} macStep_t;

	typedef struct packed {
		nnWord_t weight;
		nnWord_t activation;
		nnWord_t bias;
	} macOperand_t;

	typedef struct packed {
		logic valid;
		neuronIdx_t neuron;
		nnWord_t sum;
	} neuronSum_t;

	typedef struct packed {
		logic valid;
		neuronIdx_t neuron;
		nnWord_t value;
	} neuronOut_t;

endpackage

// ==== apbRegFile.sv ====
`include "nnLayer_defines.svh"

module apbRegFile
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input apbReq_t apbIn,
	output apbRsp_t apbOut,
	input macStep_t step,
	output macOperand_t operand,
	input neuronOut_t result,
	input logic busy,
	input logic done,
	output logic start
);

	localparam logic [`NN_ADDR_W-1:0] ctrlAddr = `NN_CTRL_ADDR;
	localparam logic [`NN_ADDR_W-1:0] statusAddr = `NN_STATUS_ADDR;
	localparam logic [`NN_ADDR_W-1:0] inputBase = `NN_INPUT_BASE;
	localparam logic [`NN_ADDR_W-1:0] biasBase = `NN_BIAS_BASE;
	localparam logic [`NN_ADDR_W-1:0] weightBase = `NN_WEIGHT_BASE;
	localparam logic [`NN_ADDR_W-1:0] outputBase = `NN_OUTPUT_BASE;

	nnWord_t inputs [`NN_NUM_INPUTS];
	nnWord_t biases [`NN_NUM_NEURONS];
	nnWord_t weights [`NN_NUM_NEURONS][`NN_NUM_INPUTS];
	nnWord_t outputs [`NN_NUM_NEURONS];

	logic access;
	logic aligned;
	inputIdx_t addrInput;
	neuronIdx_t addrNeuron;
	neuronIdx_t addrWNeuron;
	logic isCtrl;
	logic isStatus;
	logic isInput;
	logic isBias;
	logic isWeight;
	logic isOutput;
	logic isMapped;
	logic isTable;
	logic slvErr;
	logic wrEn;
	logic [`NN_WORD-1:0] rdData;

	assign access = apbIn.psel && apbIn.penable;
	assign aligned = apbIn.paddr[1:0] == 2'b00;

	// Word index fields of the address.
	assign addrInput = apbIn.paddr[5:2];
	assign addrNeuron = apbIn.paddr[4:2];
	assign addrWNeuron = apbIn.paddr[8:6];

	assign isCtrl = apbIn.paddr == ctrlAddr;
	assign isStatus = apbIn.paddr == statusAddr;
	assign isInput = aligned && apbIn.paddr[11:6] == inputBase[11:6]
		&& addrInput < `NN_NUM_INPUTS;
	assign isBias = aligned && apbIn.paddr[11:5] == biasBase[11:5];
	assign isWeight = aligned && apbIn.paddr[11:9] == weightBase[11:9]
		&& addrInput < `NN_NUM_INPUTS; // Slot 15 of each row is a hole.
	assign isOutput = aligned && apbIn.paddr[11:5] == outputBase[11:5];

	assign isMapped = isCtrl || isStatus || isInput || isBias || isWeight || isOutput;
	assign isTable = isInput || isBias || isWeight;

	assign slvErr = access && (!isMapped
		|| (apbIn.pwrite && (isStatus || isOutput || (isTable && busy))));
	assign wrEn = access && apbIn.pwrite && !slvErr;

	assign start = wrEn && isCtrl && apbIn.pwdata[0] && !busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < `NN_NUM_NEURONS; n++)
			begin
				biases[n] <= '0;
				outputs[n] <= '0;
				for (int i = 0; i < `NN_NUM_INPUTS; i++)
				begin
					weights[n][i] <= '0;
				end
			end
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
			begin
				inputs[i] <= '0;
			end
		end
		else
		begin
			if (wrEn && isInput)
				inputs[addrInput] <= apbIn.pwdata;
			if (wrEn && isBias)
				biases[addrNeuron] <= apbIn.pwdata;
			if (wrEn && isWeight)
				weights[addrWNeuron][addrInput] <= apbIn.pwdata;
			if (result.valid)
				outputs[result.neuron] <= result.value; // Write-back from datapath.
		end
	end

	always_comb
	begin
		rdData = '0;
		if (access && !apbIn.pwrite)
		begin
			if (isStatus)
				rdData = {{(`NN_WORD-2){1'b0}}, done, busy};
			else if (isInput)
				rdData = inputs[addrInput];
			else if (isBias)
				rdData = biases[addrNeuron];
			else if (isWeight)
				rdData = weights[addrWNeuron][addrInput];
			else if (isOutput)
				rdData = outputs[addrNeuron];
		end
	end

	assign apbOut = '{prdata: rdData, pready: 1'b1, pslverr: slvErr};

	// Operands for the step being issued this cycle.
	assign operand = '{
		weight: weights[step.neuron][step.inputIdx],
		activation: inputs[step.inputIdx],
		bias: biases[step.neuron]
	};

endmodule

// ==== layerControl.sv ====
`include "nnLayer_defines.svh"

module layerControl
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic resultValid,
	output macStep_t step,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		sIdle,
		sIssue,
		sDrain
	} state_t;

	state_t state;
	neuronIdx_t neuronCnt;
	inputIdx_t inputCnt;
	logic [3:0] doneCnt;
	logic lastInput;
	logic lastNeuron;
	logic lastResult;

	assign lastInput = inputCnt == inputIdx_t'(`NN_NUM_INPUTS - 1);
	assign lastNeuron = neuronCnt == neuronIdx_t'(`NN_NUM_NEURONS - 1);
	assign lastResult = resultValid && doneCnt == 4'(`NN_NUM_NEURONS - 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			neuronCnt <= '0;
			inputCnt <= '0;
			doneCnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				sIdle:
				begin
					if (start)
					begin
						state <= sIssue;
						neuronCnt <= '0;
						inputCnt <= '0;
						doneCnt <= '0;
						done <= 1'b0; // Sticky until the next run.
					end
				end
				sIssue:
				begin
					if (lastInput)
					begin
						inputCnt <= '0;
						if (lastNeuron)
							state <= sDrain;
						else
							neuronCnt <= neuronCnt + 1'b1;
					end
					else
						inputCnt <= inputCnt + 1'b1;
					if (resultValid)
						doneCnt <= doneCnt + 1'b1;
				end
				sDrain:
				begin
					if (lastResult)
					begin
						state <= sIdle;
						done <= 1'b1;
					end
					else if (resultValid)
						doneCnt <= doneCnt + 1'b1;
				end
				default:
					state <= sIdle;
			endcase
		end
	end

	assign busy = state != sIdle;

	always_comb
	begin
		step.valid = state == sIssue;
		step.first = inputCnt == '0;
		step.last = lastInput;
		step.neuron = neuronCnt;
		step.inputIdx = inputCnt;
	end

endmodule

// ==== neuronMac.sv ====
module neuronMac
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input macStep_t step,
	input macOperand_t operand,
	output neuronSum_t sum
);

	macStep_t tag;
	nnWord_t prod;
	nnWord_t biasHold;
	nnWord_t acc;
	logic sumValid;
	neuronIdx_t sumNeuron;

	// Product stage. Only the low word of the product is kept.
	always_ff @(posedge clk)
	begin
		prod <= operand.weight * operand.activation;
		biasHold <= operand.bias;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tag <= '0;
			sumValid <= 1'b0;
		end
		else
		begin
			tag <= step;
			sumValid <= tag.valid && tag.last;
		end
	end

	// Accumulate stage, 32-bit wrap-around.
	always_ff @(posedge clk)
	begin
		if (tag.valid)
		begin
			if (tag.first)
				acc <= biasHold + prod; // New neuron starts from its bias.
			else
				acc <= acc + prod;
		end
		if (tag.valid && tag.last)
			sumNeuron <= tag.neuron;
	end

	assign sum = '{valid: sumValid, neuron: sumNeuron, sum: acc};

endmodule

// ==== reluRescale.sv ====
`include "nnLayer_defines.svh"

module reluRescale
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input neuronSum_t sum,
	output neuronOut_t out
);

	nnWord_t scaled;

	// Negative sums clamp to zero.
	assign scaled = sum.sum[`NN_WORD-1] ? '0 : nnWord_t'(sum.sum[`NN_OUT_MSB:`NN_OUT_LSB]);

	always_ff @(posedge clk)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= sum.valid;
	end

	always_ff @(posedge clk)
	begin
		out.neuron <= sum.neuron;
		out.value <= scaled;
	end

endmodule

// ==== nnLayerTop.sv ====
module nnLayerTop
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input apbReq_t apbIn,
	output apbRsp_t apbOut
);

	macStep_t step;
	macOperand_t operand;
	neuronSum_t sum;
	neuronOut_t result;
	logic busy;
	logic done;
	logic start;

	apbRegFile i_apbRegFile (
		.clk(clk),
		.reset(reset),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.step(step),
		.operand(operand),
		.result(result),
		.busy(busy),
		.done(done),
		.start(start)
	);

	layerControl i_layerControl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.resultValid(result.valid), // Counts finished neurons.
		.step(step),
		.busy(busy),
		.done(done)
	);

	neuronMac i_neuronMac (
		.clk(clk),
		.reset(reset),
		.step(step),
		.operand(operand),
		.sum(sum)
	);

	reluRescale i_reluRescale (
		.clk(clk),
		.reset(reset),
		.sum(sum),
		.out(result)
	);

endmodule

// ==== tbNnLayer.sv ====
`include "nnLayer_defines.svh"

module tbNnLayer
	import nnLayerPkg::*;
();

	localparam int numIn = `NN_NUM_INPUTS;
	localparam int numNeu = `NN_NUM_NEURONS;
	localparam int runCycles = 124;
	localparam int pollCycles = 3; // One APB read.
	localparam int tableRegs = numIn + numNeu + numNeu * numIn;
	localparam int apbCount = (1 + tableRegs + numNeu) + 2 * tableRegs
		+ 5 * (tableRegs + 2 + numNeu) + 20;
	localparam int watchdogCycles = 2 * (8 + 5 * runCycles + 3 * apbCount);

	logic clk;
	logic reset;
	apbReq_t apbIn;
	apbRsp_t apbOut;

	nnWord_t xModel [numIn];
	nnWord_t bModel [numNeu];
	nnWord_t wModel [numNeu][numIn];
	logic [31:0] lcgState;
	string testName;
	int cycleCount;
	int runStart;
	event compareReq;
	event compareDone;

	nnLayerTop i_nnLayerTop (
		.clk(clk),
		.reset(reset),
		.apbIn(apbIn),
		.apbOut(apbOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic logic [`NN_ADDR_W-1:0] inputAddr(input int i);
		return `NN_INPUT_BASE + 4 * i;
	endfunction

	function automatic logic [`NN_ADDR_W-1:0] biasAddr(input int n);
		return `NN_BIAS_BASE + 4 * n;
	endfunction

	function automatic logic [`NN_ADDR_W-1:0] weightAddr(input int n, input int i);
		return `NN_WEIGHT_BASE + 4 * (16 * n + i);
	endfunction

	function automatic logic [`NN_ADDR_W-1:0] outputAddr(input int n);
		return `NN_OUTPUT_BASE + 4 * n;
	endfunction

	// Expected neuron output: wrapped biased sum, then clamp and slice.
	function automatic nnWord_t refNeuron(input int n);
		nnWord_t acc;
		acc = bModel[n];
		for (int i = 0; i < numIn; i++)
			acc = acc + wModel[n][i] * xModel[i];
		if (acc < 0)
			return '0;
		return (acc >> `NN_OUT_LSB) & ((32'd1 << (`NN_OUT_MSB - `NN_OUT_LSB + 1)) - 1);
	endfunction

	task automatic checkWord(input string name, input nnWord_t expected, input nnWord_t actual);
		if (actual !== expected)
		begin
			$display("** Error: %s: expected %h, actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic checkErr(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("** Error: %s pslverr: expected %b, actual %b", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	// Done must arrive within one run time plus one status poll.
	task automatic checkLatency(input string name, input int cycles);
		if (cycles > runCycles + pollCycles)
		begin
			$display("%s: done came %0d cycles after start, so the run was restarted.",
				name, cycles);
			$display("SIMULATION FAILED");
			$fatal(1, "Run restarted.");
		end
	endtask

	// Setup and access phase, sampled in the middle of the access cycle.
	task automatic apbAccess(input logic write, input logic [`NN_ADDR_W-1:0] addr,
		input nnWord_t wdata, output nnWord_t rdata, output logic err);
		@(negedge clk);
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = write;
		apbIn.paddr = addr;
		apbIn.pwdata = wdata;
		@(negedge clk);
		apbIn.penable = 1'b1;
		#1;
		rdata = apbOut.prdata;
		err = apbOut.pslverr;
		if (apbOut.pready !== 1'b1)
		begin
			$display("** Error: %s pready at %h: expected 1, actual %b", testName, addr,
				apbOut.pready);
			$display("SIMULATION FAILED");
			$fatal(1, "Stopped at the first mismatch.");
		end
		@(negedge clk);
		apbIn = '0; // Back to idle.
	endtask

	task automatic apbWrite(input string name, input logic [`NN_ADDR_W-1:0] addr,
		input nnWord_t data, input logic expErr);
		nnWord_t rdata;
		logic err;
		apbAccess(1'b1, addr, data, rdata, err);
		checkErr(name, expErr, err);
	endtask

	task automatic apbRead(input logic [`NN_ADDR_W-1:0] addr, output nnWord_t data,
		output logic err);
		apbAccess(1'b0, addr, '0, data, err);
	endtask

	task automatic readCheck(input string name, input logic [`NN_ADDR_W-1:0] addr,
		input nnWord_t expected);
		nnWord_t data;
		logic err;
		apbRead(addr, data, err);
		checkErr(name, 1'b0, err);
		checkWord(name, expected, data);
	endtask

	task automatic readRejected(input string name, input logic [`NN_ADDR_W-1:0] addr);
		nnWord_t data;
		logic err;
		apbRead(addr, data, err);
		checkErr(name, 1'b1, err);
	endtask

	task automatic randomizeModel();
		for (int i = 0; i < numIn; i++)
			xModel[i] = nextRand();
		for (int n = 0; n < numNeu; n++)
		begin
			bModel[n] = nextRand();
			for (int i = 0; i < numIn; i++)
				wModel[n][i] = nextRand();
		end
	endtask

	// Mix of negative sums, large sums and sums that wrap past 2^32.
	task automatic setDirected();
		nnWord_t w [numNeu];
		w = '{0, 1, -1000, 32'h8000, 32'h2000, 32'h1000, 0, 0};
		bModel = '{-100000, 32'h3000_0000, 0, 32'h9234_5678, 0, 32'h2000_0000, -1,
			32'h7FFF_FFFF};
		for (int i = 0; i < numIn; i++)
			xModel[i] = 32'h0001_0000;
		for (int n = 0; n < numNeu; n++)
			for (int i = 0; i < numIn; i++)
				wModel[n][i] = w[n];
	endtask

	task automatic loadLayer();
		for (int i = 0; i < numIn; i++)
			apbWrite("load input", inputAddr(i), xModel[i], 1'b0);
		for (int n = 0; n < numNeu; n++)
		begin
			apbWrite("load bias", biasAddr(n), bModel[n], 1'b0);
			for (int i = 0; i < numIn; i++)
				apbWrite("load weight", weightAddr(n, i), wModel[n][i], 1'b0);
		end
	endtask

	task automatic checkTables(input string name, input logic zero);
		for (int i = 0; i < numIn; i++)
			readCheck({name, " input"}, inputAddr(i), zero ? '0 : xModel[i]);
		for (int n = 0; n < numNeu; n++)
		begin
			readCheck({name, " bias"}, biasAddr(n), zero ? '0 : bModel[n]);
			for (int i = 0; i < numIn; i++)
				readCheck({name, " weight"}, weightAddr(n, i), zero ? '0 : wModel[n][i]);
		end
	endtask

	task automatic waitDone();
		nnWord_t status;
		logic err;
		status = '0;
		while (status[1] !== 1'b1)
		begin
			apbRead(`NN_STATUS_ADDR, status, err);
			checkErr({testName, " status poll"}, 1'b0, err);
		end
	endtask

	task automatic runLayer(input string name);
		testName = name;
		apbWrite({name, " start"}, `NN_CTRL_ADDR, 32'h1, 1'b0);
		waitDone();
		-> compareReq;
		@(compareDone);
		readCheck({name, " status"}, `NN_STATUS_ADDR, 32'h2);
	endtask

	// Reads each output register after a run and checks it against the model.
	initial
	begin
		forever
		begin
			@(compareReq);
			for (int n = 0; n < numNeu; n++)
				readCheck($sformatf("%s output %0d", testName, n), outputAddr(n), refNeuron(n));
			-> compareDone;
		end
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run hung.", watchdogCycles);
		$display("SIMULATION FAILED");
		$fatal(1, "Timeout.");
	end

	initial
	begin
		reset = 1'b1;
		apbIn = '0;
		lcgState = 32'd6611;
		testName = "reset";
		repeat (8) @(negedge clk);
		reset = 1'b0;

		readCheck("reset status", `NN_STATUS_ADDR, '0);
		checkTables("reset", 1'b1);
		for (int n = 0; n < numNeu; n++)
			readCheck("reset output", outputAddr(n), '0);

		testName = "readback";
		randomizeModel();
		loadLayer();
		checkTables("readback", 1'b0);

		for (int r = 0; r < 3; r++)
		begin
			randomizeModel();
			loadLayer();
			runLayer($sformatf("random run %0d", r));
		end

		setDirected();
		loadLayer();
		runLayer("directed run");

		testName = "errors";
		apbWrite("unmapped write", weightAddr(0, 15), 32'hDEAD_BEEF, 1'b1);
		readRejected("unmapped read", weightAddr(0, 15));
		readCheck("weight beside hole", weightAddr(0, 14), wModel[0][14]);
		readCheck("weight after hole", weightAddr(1, 0), wModel[1][0]);
		apbWrite("unmapped far write", 12'h800, 32'h1, 1'b1);
		apbWrite("output write", outputAddr(3), 32'h1234_5678, 1'b1);
		readCheck("output unchanged", outputAddr(3), refNeuron(3));
		apbWrite("status write", `NN_STATUS_ADDR, 32'h3, 1'b1);
		readCheck("status unchanged", `NN_STATUS_ADDR, 32'h2);
		readCheck("ctrl reads zero", `NN_CTRL_ADDR, '0);

		randomizeModel();
		loadLayer();
		testName = "busy run";
		apbWrite("busy start", `NN_CTRL_ADDR, 32'h1, 1'b0);
		runStart = cycleCount;
		readCheck("status while busy", `NN_STATUS_ADDR, 32'h1);
		apbWrite("weight write while busy", weightAddr(2, 3), nextRand(), 1'b1);
		apbWrite("start while busy", `NN_CTRL_ADDR, 32'h1, 1'b0);
		waitDone();
		checkLatency("busy run", cycleCount - runStart);
		-> compareReq;
		@(compareDone);
		readCheck("busy status", `NN_STATUS_ADDR, 32'h2);
		readCheck("weight unchanged", weightAddr(2, 3), wModel[2][3]);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== nnLayer.f ====
+incdir+.
nnLayerPkg.sv
apbRegFile.sv
layerControl.sv
neuronMac.sv
reluRescale.sv
nnLayerTop.sv
tbNnLayer.sv
